/* hdl/crc32_dibit.sv */
`timescale 1ns/1ps

module crc32_dibit
  import eth_frame_pkg::*;
(
  input  logic        eth_refclk,
  input  logic        sys_rst,
  input  logic        clear,
  input  logic        enable,
  input  logic [1:0]  data,
  output logic [31:0] crc
);

  // one bit of the lsb first shift register
  function automatic logic [31:0] crc_step(input logic [31:0] cur, input logic din);
    logic fb;
    fb = cur[0] ^ din;
    return (cur >> 1) ^ (fb ? CRC_POLY_REFLECTED : 32'h0);
  endfunction

  logic [31:0] crc_next;

  // data[0] is first on the wire so it goes in first
  assign crc_next = crc_step(crc_step(crc, data[0]), data[1]);

  always_ff @(posedge eth_refclk) begin
    if (sys_rst || clear) begin
      crc <= CRC_INIT;
    end else if (enable) begin
      crc <= crc_next;  // two bit steps per dibit
    end
  end

endmodule

/* hdl/eth_frame_pkg.sv */
package eth_frame_pkg;

  // one rmii transfer slot
  typedef struct packed {
    logic       valid;  // high when data carries a real dibit
    logic [1:0] data;   // bit 0 leaves first
  } dibit_t;

  // word rebuilt from the line
  typedef struct packed {
    logic        valid;  // single cycle strobe per frame
    logic [31:0] word;   // first byte after sfd sits in 31:24
  } agg_word_t;

  // frame sequencer states, in line order
  typedef enum logic [2:0] {
    ST_GAP,
    ST_PREAMBLE,
    ST_SFD,
    ST_HEADER,
    ST_PAYLOAD,
    ST_FCS
  } packer_state_t;

  // byte counts of each frame section
  localparam int          PREAMBLE_BYTES = 7;
  localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
  localparam logic [7:0]  SFD_BYTE       = 8'hD5;
  localparam int          HEADER_BYTES   = 14;  // dest mac, src mac, ethertype
  localparam int          FCS_BYTES      = 4;
  localparam int          GAP_BYTES      = 12;  // 96 bit times

  // ieee 802.3 crc-32, lsb first form
  localparam logic [31:0] CRC_INIT           = 32'hFFFFFFFF;
  localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB88320;

endpackage

/* hdl/eth_packer.sv */
`timescale 1ns/1ps

module eth_packer
  import eth_frame_pkg::*;
#(
  parameter int          PAYLOAD_BYTES = 46,
  parameter logic [47:0] DEST_MAC      = 48'h12_34_56_78_9A_BC,
  parameter logic [47:0] SRC_MAC       = 48'h02_00_00_C0_FF_EE,
  parameter logic [15:0] ETHERTYPE     = 16'h88B5
)(
  input  logic       eth_refclk,
  input  logic       sys_rst,
  input  dibit_t     dibit,
  output logic       stall,
  output logic       txen,
  output logic [1:0] txd
);

  // wide enough for the longest section
  localparam int CNT_W =
    $clog2(PAYLOAD_BYTES > HEADER_BYTES ? PAYLOAD_BYTES : HEADER_BYTES);

  // header bytes, first on the wire at the top
  localparam logic [HEADER_BYTES*8-1:0] HEADER = {DEST_MAC, SRC_MAC, ETHERTYPE};

  packer_state_t    state;
  logic [CNT_W-1:0] byte_cnt;    // byte inside the current section
  logic [1:0]       dibit_cnt;   // dibit inside the current byte
  logic             byte_done;
  logic             last_byte;
  logic             state_done;  // final cycle of the section
  logic [7:0]       hdr_byte;
  logic [1:0]       line_dibit;  // what txd gets next edge
  logic [31:0]      crc;
  logic [31:0]      fcs;
  logic             crc_clear;
  logic             crc_en;

  assign byte_done  = (dibit_cnt == 2'd3);
  assign state_done = byte_done && last_byte;

  always_comb begin
    case (state)
      ST_GAP:      last_byte = (byte_cnt == CNT_W'(GAP_BYTES - 1));
      ST_PREAMBLE: last_byte = (byte_cnt == CNT_W'(PREAMBLE_BYTES - 1));
      ST_SFD:      last_byte = 1'b1;  // single byte
      ST_HEADER:   last_byte = (byte_cnt == CNT_W'(HEADER_BYTES - 1));
      ST_PAYLOAD:  last_byte = (byte_cnt == CNT_W'(PAYLOAD_BYTES - 1));
      ST_FCS:      last_byte = (byte_cnt == CNT_W'(FCS_BYTES - 1));
      default:     last_byte = 1'b1;
    endcase
  end

  // sequencer
  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      state     <= ST_GAP;  // frame starts after a full gap
      byte_cnt  <= '0;
      dibit_cnt <= 2'd0;
    end else begin
      dibit_cnt <= dibit_cnt + 2'd1;  // one dibit every cycle
      if (state_done) begin
        byte_cnt <= '0;
        case (state)
          ST_GAP:      state <= ST_PREAMBLE;
          ST_PREAMBLE: state <= ST_SFD;
          ST_SFD:      state <= ST_HEADER;
          ST_HEADER:   state <= ST_PAYLOAD;
          ST_PAYLOAD:  state <= ST_FCS;
          default:     state <= ST_GAP;
        endcase
      end else if (byte_done) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // byte_cnt only in range during ST_HEADER
  assign hdr_byte = HEADER[(HEADER_BYTES - 1 - byte_cnt) * 8 +: 8];
  assign fcs      = ~crc;

  always_comb begin
    case (state)
      ST_PREAMBLE: line_dibit = PREAMBLE_BYTE[{dibit_cnt, 1'b0} +: 2];
      ST_SFD:      line_dibit = SFD_BYTE[{dibit_cnt, 1'b0} +: 2];
      ST_HEADER:   line_dibit = hdr_byte[{dibit_cnt, 1'b0} +: 2];
      ST_PAYLOAD:  line_dibit = dibit.valid ? dibit.data : 2'b00;
      ST_FCS:      line_dibit = fcs[{byte_cnt[1:0], dibit_cnt, 1'b0} +: 2];  // lsb byte first
      default:     line_dibit = 2'b00;
    endcase
  end

  // serializer runs one cycle ahead so its dibits land in ST_PAYLOAD
  assign stall = !((state == ST_HEADER && state_done) ||
                   (state == ST_PAYLOAD && !state_done));

  // crc over header and payload, restarted on every sfd
  assign crc_clear = (state == ST_SFD);
  assign crc_en    = (state == ST_HEADER) || (state == ST_PAYLOAD);

  crc32_dibit crc32_dibit_inst (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .clear      (crc_clear),
    .enable     (crc_en),
    .data       (line_dibit),
    .crc        (crc)
  );

  // line outputs, one cycle behind the state
  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      txen <= 1'b0;
      txd  <= 2'b00;
    end else begin
      txen <= (state != ST_GAP);
      txd  <= line_dibit;
    end
  end

endmodule

/* hdl/frame_aggregator.sv */
`timescale 1ns/1ps

module frame_aggregator
  import eth_frame_pkg::*;
(
  input  logic        eth_refclk,
  input  logic        sys_rst,
  input  logic        txen,
  input  logic [1:0]  txd,
  output agg_word_t   agg,
  output logic [13:0] frame_count
);

  typedef enum logic [1:0] {
    AG_HUNT,     // waiting for sfd
    AG_COLLECT,  // taking 16 dibits
    AG_DONE      // rest of frame ignored
  } agg_state_t;

  agg_state_t  state;
  logic [7:0]  last_dibits;  // newest dibit on top
  logic [7:0]  shifted;
  logic [3:0]  dibit_cnt;
  logic        txen_q;       // for edge detect
  logic        valid_q;
  logic [31:0] word_q;

  // lsb first arrival rebuilds the byte in order
  assign shifted = {txd, last_dibits[7:2]};

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      state       <= AG_HUNT;
      dibit_cnt   <= 4'd0;
      valid_q     <= 1'b0;
      txen_q      <= 1'b0;
      frame_count <= '0;
    end else begin
      valid_q <= 1'b0;
      txen_q  <= txen;
      if (txen && !txen_q) begin
        frame_count <= frame_count + 1'b1;  // one per frame start
      end
      case (state)
        AG_HUNT: begin
          if (txen && shifted == SFD_BYTE) begin
            state     <= AG_COLLECT;
            dibit_cnt <= 4'd0;
          end
        end
        AG_COLLECT: begin
          if (!txen) begin
            state <= AG_HUNT;  // frame cut short
          end else begin
            dibit_cnt <= dibit_cnt + 4'd1;
            if (dibit_cnt == 4'd15) begin
              valid_q <= 1'b1;
              state   <= AG_DONE;
            end
          end
        end
        default: if (!txen) state <= AG_HUNT;
      endcase
    end
  end

  // sfd window and word, no reset needed
  always_ff @(posedge eth_refclk) begin
    last_dibits <= txen ? shifted : 8'h00;  // idle line never matches
    if (state == AG_COLLECT && txen) begin
      word_q[{~dibit_cnt[3:2], dibit_cnt[1:0], 1'b0} +: 2] <= txd;  // byte 0 to 31:24
    end
  end

  assign agg.valid = valid_q;
  assign agg.word  = word_q;

endmodule

/* hdl/pixel_serializer.sv */
`timescale 1ns/1ps

module pixel_serializer
  import eth_frame_pkg::*;
  import video_pkg::*;
(
  input  logic        eth_refclk,
  input  logic        sys_rst,
  input  pixel_t      pixel,
  input  logic        stall,
  output dibit_t      dibit,
  output pixel_addr_t pixel_addr
);

  logic [1:0] dibit_idx;   // next dibit of the byte to go out
  pixel_t     held_pixel;  // byte being split up
  logic       valid_q;
  logic [1:0] data_q;

  // control path
  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      dibit_idx  <= 2'd0;
      pixel_addr <= '0;
      valid_q    <= 1'b0;
    end else if (stall) begin
      valid_q <= 1'b0;  // hold position, nothing emitted
    end else begin
      valid_q   <= 1'b1;
      dibit_idx <= dibit_idx + 2'd1;
      // byte latched this cycle, so point at the next one
      // gives the pixel source three cycles to catch up
      if (dibit_idx == 2'd0) begin
        pixel_addr <= pixel_addr + 1'b1;
      end
    end
  end

  // data path
  always_ff @(posedge eth_refclk) begin
    if (!stall) begin
      if (dibit_idx == 2'd0) begin
        held_pixel <= pixel;       // sample with the first dibit
        data_q     <= pixel[1:0];  // lsb dibit goes straight out
      end else begin
        data_q <= held_pixel[{dibit_idx, 1'b0} +: 2];
      end
    end
  end

  assign dibit.valid = valid_q;
  assign dibit.data  = data_q;

endmodule

/* hdl/rmii_pixel_tx.sv */
`timescale 1ns/1ps

module rmii_pixel_tx
  import eth_frame_pkg::*;
  import video_pkg::*;
#(
  parameter int          PAYLOAD_BYTES = 46,                   // minimum ethernet payload
  parameter logic [47:0] DEST_MAC      = 48'h12_34_56_78_9A_BC,
  parameter logic [47:0] SRC_MAC       = 48'h02_00_00_C0_FF_EE, // locally administered
  parameter logic [15:0] ETHERTYPE     = 16'h88B5,             // local experimental type
  parameter int          SCAN_DIV      = 50000                 // 1 khz per digit at 50 mhz
)(
  input  logic         eth_refclk,
  input  logic         sys_rst,
  input  pixel_t       pixel,
  output pixel_addr_t  pixel_addr,
  output logic         eth_txen,
  output logic [1:0]   eth_txd,
  output agg_word_t    agg,
  output logic [13:0]  frame_count,
  output seg_pattern_t cat,
  output logic [7:0]   an
);

  dibit_t rbo_dibit;  // serializer to packer
  logic   stall;      // packer back to serializer

  pixel_serializer pixel_serializer_inst (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .pixel      (pixel),
    .stall      (stall),
    .dibit      (rbo_dibit),
    .pixel_addr (pixel_addr)
  );

  eth_packer #(
    .PAYLOAD_BYTES (PAYLOAD_BYTES),
    .DEST_MAC      (DEST_MAC),
    .SRC_MAC       (SRC_MAC),
    .ETHERTYPE     (ETHERTYPE)
  ) eth_packer_inst (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .dibit      (rbo_dibit),
    .stall      (stall),
    .txen       (eth_txen),
    .txd        (eth_txd)
  );

  // listens to the line as sent
  frame_aggregator frame_aggregator_inst (
    .eth_refclk  (eth_refclk),
    .sys_rst     (sys_rst),
    .txen        (eth_txen),
    .txd         (eth_txd),
    .agg         (agg),
    .frame_count (frame_count)
  );

  seven_segment_controller #(
    .SCAN_DIV (SCAN_DIV)
  ) seven_segment_controller_inst (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .agg        (agg),
    .cat        (cat),
    .an         (an)
  );

endmodule

/* hdl/seven_segment_controller.sv */
`timescale 1ns/1ps

module seven_segment_controller
  import eth_frame_pkg::*;
  import video_pkg::*;
#(
  parameter int SCAN_DIV = 50000
)(
  input  logic         eth_refclk,
  input  logic         sys_rst,
  input  agg_word_t    agg,
  output seg_pattern_t cat,
  output logic [7:0]   an
);

  localparam int DIV_W = $clog2(SCAN_DIV + 1);

  logic [31:0]      shown;      // word on the display
  logic [DIV_W-1:0] div_cnt;    // refclk cycles on this digit
  logic [2:0]       digit_idx;
  hex_digit_t       nibble;

  // hex to active low segments, g down to a
  function automatic seg_pattern_t seg_lookup(input hex_digit_t d);
    case (d)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;  // lower case b
      4'hC: return 7'h46;
      4'hD: return 7'h21;  // lower case d
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      shown     <= 32'h0;
      div_cnt   <= '0;
      digit_idx <= 3'd0;
    end else begin
      if (agg.valid) shown <= agg.word;  // keep until next frame
      if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
        div_cnt   <= '0;
        digit_idx <= (digit_idx == 3'(NUM_DIGITS - 1)) ? 3'd0 : digit_idx + 3'd1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign nibble = shown[{digit_idx, 2'b00} +: 4];  // an[0] shows 3:0
  assign an     = ~(8'b1 << digit_idx);            // one anode low
  assign cat    = seg_lookup(nibble);

endmodule

/* hdl/video_pkg.sv */
package video_pkg;

  // one pixel, one payload byte
  typedef logic [7:0] pixel_t;

  // pixel index, free running across frames
  typedef logic [23:0] pixel_addr_t;

  // value shown on a single display digit
  typedef logic [3:0] hex_digit_t;

  // segment lines g down to a
  // active low, so 0 lights a segment
  typedef logic [6:0] seg_pattern_t;

  // digits on the board
  localparam int NUM_DIGITS = 8;

endpackage

/* rmii_pixel_tx.f */
hdl/eth_frame_pkg.sv
hdl/video_pkg.sv
hdl/pixel_serializer.sv
hdl/crc32_dibit.sv
hdl/eth_packer.sv
hdl/frame_aggregator.sv
hdl/seven_segment_controller.sv
hdl/rmii_pixel_tx.sv
verification/rmii_pixel_tx_assertions.sv
verification/tb_rmii_pixel_tx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rmii_pixel_tx testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rmii_pixel_tx.f \
  --top-module tb_rmii_pixel_tx \
  -o sim_tb_rmii_pixel_tx

# nonzero exit status on any failure in the run
./obj_dir/sim_tb_rmii_pixel_tx

/* verification/rmii_pixel_tx_assertions.sv */
`timescale 1ns/1ps

module rmii_pixel_tx_assertions
  import eth_frame_pkg::*;
#(
  parameter int PAYLOAD_BYTES = 46
)(
  input logic eth_refclk,
  input logic sys_rst,
  input logic txen,
  input logic stall
);

  // dibit cycles of one frame with txen high
  localparam int FRAME_CYCLES =
    (PREAMBLE_BYTES + 1 + HEADER_BYTES + PAYLOAD_BYTES + FCS_BYTES) * 4;
  localparam int GAP_CYCLES = GAP_BYTES * 4;

  logic [15:0] high_cnt;  // consecutive txen high cycles
  logic [7:0]  low_cnt;   // consecutive low cycles, saturating

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      high_cnt <= '0;
      low_cnt  <= '0;
    end else begin
      high_cnt <= txen ? high_cnt + 16'd1 : 16'd0;
      low_cnt  <= txen ? 8'd0 : (low_cnt == 8'hFF ? low_cnt : low_cnt + 8'd1);
    end
  end

  // serializer only runs inside a frame
  a_stall_when_idle: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    !txen |-> stall) else $error("stall low while txen is low");

  a_frame_not_long: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    txen |-> (high_cnt < 16'(FRAME_CYCLES))) else $error("txen high past frame length");

  a_frame_full: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    $fell(txen) |-> (high_cnt == 16'(FRAME_CYCLES))) else $error("txen fell before frame end");

  // inter-frame gap of 96 bit times
  a_gap_length: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    $rose(txen) |-> (low_cnt >= 8'(GAP_CYCLES))) else $error("txen rose inside the gap");

endmodule

/* verification/tb_rmii_pixel_tx.sv */
`timescale 1ns/1ps

module tb_rmii_pixel_tx
  import eth_frame_pkg::*;
  import video_pkg::*;
;

  localparam int PAYLOAD_BYTES  = 46;
  localparam int FRAME_BYTES    = PREAMBLE_BYTES + 1 + HEADER_BYTES + PAYLOAD_BYTES + FCS_BYTES;
  localparam int NUM_FRAMES     = 3;
  localparam int TIMEOUT_CYCLES = 1000;  // per wait loop
  localparam int SCAN_CYCLES    = 40;    // more than one full display rotation

  logic         eth_refclk;
  logic         sys_rst;
  pixel_t       pixel;
  pixel_addr_t  pixel_addr;
  logic         eth_txen;
  logic [1:0]   eth_txd;
  agg_word_t    agg;
  logic [13:0]  frame_count;
  seg_pattern_t cat;
  logic [7:0]   an;

  logic [7:0] patterns [0:29];  // 16 pixels, then 14 header bytes
  logic [7:0] frame_bytes[$];   // bytes rebuilt from the line
  logic [7:0] exp_bytes[$];
  agg_word_t  exp_agg;
  int         agg_pulses = 0;

  rmii_pixel_tx #(
    .PAYLOAD_BYTES (PAYLOAD_BYTES),
    .SCAN_DIV      (4)  // fast digit scan
  ) rmii_pixel_tx_inst (
    .eth_refclk  (eth_refclk),
    .sys_rst     (sys_rst),
    .pixel       (pixel),
    .pixel_addr  (pixel_addr),
    .eth_txen    (eth_txen),
    .eth_txd     (eth_txd),
    .agg         (agg),
    .frame_count (frame_count),
    .cat         (cat),
    .an          (an)
  );

  bind eth_packer rmii_pixel_tx_assertions #(
    .PAYLOAD_BYTES (PAYLOAD_BYTES)
  ) packer_assertions_inst (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .txen       (txen),
    .stall      (stall)
  );

  initial begin
    eth_refclk = 1'b0;
    forever #2 eth_refclk = ~eth_refclk;  // 250 mhz sim clock
  end

  // pixel source answers the current address
  always @(posedge eth_refclk) pixel <= patterns[pixel_addr[3:0]];

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected %02h actual %02h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_word(string name, agg_word_t exp, agg_word_t act);
    if (act.word !== exp.word) begin
      $display("MISMATCH time=%0t %s expected %08h actual %08h", $time, name, exp.word,
               act.word);
      stop_with_failure();
    end
  endtask

  task automatic check_count(string name, logic [13:0] exp, logic [13:0] act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(string name, pixel_addr_t exp, pixel_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_seg(string name, seg_pattern_t exp, seg_pattern_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected %07b actual %07b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // bitwise ieee crc-32, lsb of each byte first
  function automatic logic [31:0] crc_byte(logic [31:0] crc_in, logic [7:0] b);
    logic [31:0] c;
    c = crc_in;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ b[i]) ? ((c >> 1) ^ CRC_POLY_REFLECTED) : (c >> 1);
    end
    return c;
  endfunction

  // common hex font, lit segments as ones, g down to a
  function automatic seg_pattern_t hex_to_seg(hex_digit_t d);
    logic [6:0] lit;
    case (d)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;  // board drives segments low
  endfunction

  // whole frame as it should appear on the line
  task automatic build_expected(int frame_idx);
    logic [31:0] crc;
    logic [7:0]  b;
    exp_bytes.delete();
    crc = CRC_INIT;
    for (int i = 0; i < PREAMBLE_BYTES; i++) exp_bytes.push_back(PREAMBLE_BYTE);
    exp_bytes.push_back(SFD_BYTE);
    for (int i = 0; i < HEADER_BYTES; i++) begin
      b = patterns[16 + i];
      exp_bytes.push_back(b);
      crc = crc_byte(crc, b);
    end
    for (int i = 0; i < PAYLOAD_BYTES; i++) begin
      b = patterns[(frame_idx * PAYLOAD_BYTES + i) % 16];  // addressing never restarts
      exp_bytes.push_back(b);
      crc = crc_byte(crc, b);
    end
    crc = ~crc;
    for (int i = 0; i < FCS_BYTES; i++) exp_bytes.push_back(crc[8*i +: 8]);  // lsb byte first
  endtask

  task automatic wait_frame_start(output int low_cycles);
    low_cycles = 0;
    while (eth_txen !== 1'b1) begin
      low_cycles++;
      if (low_cycles > TIMEOUT_CYCLES) begin
        $display("timeout while waiting for eth_txen to rise");
        stop_with_failure();
      end
      @(negedge eth_refclk);
    end
  endtask

  // one dibit per cycle, lowest dibit of a byte first
  task automatic capture_frame(output int n_dibits);
    logic [7:0] cur;
    n_dibits = 0;
    cur = '0;
    frame_bytes.delete();
    while (eth_txen === 1'b1) begin
      cur[2*(n_dibits % 4) +: 2] = eth_txd;
      if (n_dibits % 4 == 3) frame_bytes.push_back(cur);
      n_dibits++;
      if (n_dibits > TIMEOUT_CYCLES) begin
        $display("timeout, eth_txen stuck high");
        stop_with_failure();
      end
      @(negedge eth_refclk);
    end
  endtask

  task automatic check_display();
    int         idx;
    logic [7:0] seen;  // digits visited
    seen = '0;
    for (int n = 0; n < SCAN_CYCLES; n++) begin
      @(negedge eth_refclk);
      idx = -1;
      for (int d = 0; d < 8; d++) if (an == ~(8'b1 << d)) idx = d;
      if (idx < 0) begin
        $display("anode pattern %08b does not select exactly one digit", an);
        stop_with_failure();
      end
      seen[idx] = 1'b1;
      check_seg($sformatf("cat on digit %0d", idx), hex_to_seg(exp_agg.word[4*idx +: 4]), cat);
    end
    if (seen != 8'hFF) begin
      $display("display scan skipped a digit, visited %08b", seen);
      stop_with_failure();
    end
  endtask

  // agg strobe once per frame, mid frame
  always @(negedge eth_refclk) begin
    if (!sys_rst && agg.valid === 1'b1) begin
      agg_pulses <= agg_pulses + 1;
      check_word("agg.word", exp_agg, agg);
    end
  end

  // overall limit on the run
  initial begin
    #20000;
    $display("simulation ran past its time limit");
    stop_with_failure();
  end

  initial begin
    int low_cycles;
    int n_dibits;
    sys_rst = 1'b1;
    pixel   = '0;
    $readmemh("verification/tx_patterns.mem", patterns);
    exp_agg = {1'b1, patterns[16], patterns[17], patterns[18], patterns[19]};
    repeat (2) @(posedge eth_refclk);
    sys_rst <= 1'b0;
    @(negedge eth_refclk);
    for (int k = 0; k < NUM_FRAMES; k++) begin
      wait_frame_start(low_cycles);
      if (low_cycles < GAP_BYTES * 4) begin
        $display("gap before frame %0d lasted only %0d cycles", k, low_cycles);
        stop_with_failure();
      end
      capture_frame(n_dibits);
      check_count($sformatf("frame %0d dibits", k), 14'(FRAME_BYTES * 4), 14'(n_dibits));
      build_expected(k);
      for (int i = 0; i < FRAME_BYTES; i++) begin
        check_byte($sformatf("frame %0d byte %0d", k, i), exp_bytes[i], frame_bytes[i]);
      end
      check_count("agg.valid pulses", 14'(k + 1), 14'(agg_pulses));
      check_count("frame_count", 14'(k + 1), frame_count);
      // one address per payload byte, carried across frames
      check_addr("pixel_addr", pixel_addr_t'((k + 1) * PAYLOAD_BYTES), pixel_addr);
    end
    check_display();  // runs in the gap after the last frame
    $display("Test passed");
    $finish;
  end

endmodule

/* verification/tx_patterns.mem */
// pixel table, one byte per line, entry n served when pixel_addr[3:0] == n
// then the 14 header bytes expected after the sfd, in line order
3C
A5
0F
F0
81
7E
12
ED
69
96
C3
5A
01
FE
47
B8
// dest mac
12
34
56
78
9A
BC
// src mac
02
00
00
C0
FF
EE
// ethertype
88
B5
